// File: project.f
conv_pkg.sv
conv_cfg_regs.sv
weight_loader.sv
window_gather.sv
conv_sequencer.sv
conv_feeder_top.sv
conv_feeder_chk.sv
tb_conv_feeder.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_conv_feeder
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(wildcard *.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_conv_feeder.sv
`timescale 1ns/1ps

module tb_conv_feeder;
    import conv_pkg::*;

    localparam int MEM_BYTES = 4096;
    // batches per layer run: 1x1 (40), 3x3 s2 (24), 2x2 remainder (24), 3x3 s2 random ready (24)
    localparam int TOTAL_BATCHES = 40 + 24 + 24 + 24;
    localparam int LIMIT_CYCLES  = TOTAL_BATCHES * 200 + 2000;

    logic       clk;
    logic       rst;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    sram_req_t  wsram;
    sram_word_t wsram_rdata;
    sram_req_t  isram;
    sram_word_t isram_rdata;
    logic       mac_valid;
    logic       mac_ready;
    mac_batch_t mac_batch;

    logic [7:0] img_mem [MEM_BYTES];
    logic [7:0] w_mem [MEM_BYTES];

    integer seed;
    int     errors;
    int     checks;
    int     received;
    int     expected_batches;
    bit     random_ready;

    // layer geometry as programmed, plus the derived values
    int img_rows;
    int img_cols;
    int ker_rows;
    int ker_cols;
    int in_ch;
    int out_ch;
    int stride_row;
    int stride_col;
    int o_rows;
    int o_cols;
    int mpg;
    int groups;

    conv_feeder_top conv_feeder_top_i (
        .clk           (clk),
        .rst           (rst),
        .apb_req_i     (apb_req),
        .apb_rsp_o     (apb_rsp),
        .wsram_o       (wsram),
        .wsram_rdata_i (wsram_rdata),
        .isram_o       (isram),
        .isram_rdata_i (isram_rdata),
        .mac_valid_o   (mac_valid),
        .mac_ready_i   (mac_ready),
        .mac_batch_o   (mac_batch)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_equal(string what, logic [511:0] got, logic [511:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // offsets decoded by the register block
    function automatic bit is_mapped(logic [7:0] addr);
        return addr inside {REG_CTRL, REG_STATUS, REG_IMG, REG_KER, REG_OCH,
                            REG_STRIDE, REG_INFO};
    endfunction

    task automatic apb_write(logic [7:0] addr, logic [31:0] data);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_read(logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(posedge clk);
        data = apb_rsp.prdata;
        // zero wait states, error only off the register map
        check_equal("apb pready", apb_rsp.pready, 1'b1);
        check_equal("apb pslverr", apb_rsp.pslverr, !is_mapped(addr));
        #1;
        apb_req = '0;
    endtask

    // program the geometry and derive what the register block should report
    task automatic set_layer(int ir, int ic, int kr, int kc, int ich, int och, int sr, int sc);
        img_rows   = ir;
        img_cols   = ic;
        ker_rows   = kr;
        ker_cols   = kc;
        in_ch      = ich;
        out_ch     = och;
        stride_row = sr;
        stride_col = sc;
        o_rows = (ir - kr) / sr + 1;
        o_cols = (ic - kc) / sc + 1;
        mpg    = kr * kc * ich;
        groups = (mpg > MAC_LANES) ? 0 : MAC_LANES / mpg;
        groups = (groups < och) ? groups : och;
        apb_write(REG_IMG, {16'b0, 8'(ic), 8'(ir)});
        apb_write(REG_KER, {8'b0, 8'(ich), 8'(kc), 8'(kr)});
        apb_write(REG_OCH, {24'b0, 8'(och)});
        apb_write(REG_STRIDE, {24'b0, 4'(sc), 4'(sr)});
    endtask

    function automatic sram_word_t read_word(bit from_image, logic [SRAM_AW-1:0] waddr);
        sram_word_t w;
        int a;
        w = '0;
        for (int b = 0; b < SRAM_BYTES; b++) begin
            a = int'(waddr) * SRAM_BYTES + b;
            if (a < MEM_BYTES) begin
                w[b*8 +: 8] = from_image ? img_mem[a] : w_mem[a];
            end
        end
        return w;
    endfunction

    // batch n of the layer, built from the memories and the batch rules
    function automatic mac_batch_t expected_batch(int n);
        mac_batch_t b;
        int per_pos;
        int pos;
        int r;
        int c;
        int oc;
        int ng;
        int kr;
        int kc;
        int ch;
        per_pos = (out_ch + groups - 1) / groups;
        pos = n / per_pos;
        r   = pos / o_cols;
        c   = pos % o_cols;
        oc  = (n % per_pos) * groups;
        ng  = (groups < out_ch - oc) ? groups : out_ch - oc;
        b = '0;
        for (int g = 0; g < ng; g++) begin
            for (int j = 0; j < mpg; j++) begin
                kr = j / (ker_cols * in_ch);
                kc = (j / in_ch) % ker_cols;
                ch = j % in_ch;
                b.data[(g*mpg + j)*8 +: 8] = img_mem[((r*stride_row + kr) * img_cols
                                             + c*stride_col + kc) * in_ch + ch];
                b.weight[(g*mpg + j)*8 +: 8] = w_mem[(oc + g) * mpg + j];
            end
        end
        b.num_groups     = 8'(ng);
        b.macs_per_group = 8'(mpg);
        b.out_row        = 8'(r);
        b.out_col        = 8'(c);
        b.oc_base        = 8'(oc);
        return b;
    endfunction

    // both SRAMs answer one cycle after en
    always @(posedge clk) begin
        sram_req_t wq;
        sram_req_t iq;
        wq = wsram;
        iq = isram;
        #1;
        if (wq.en) begin
            wsram_rdata = read_word(1'b0, wq.addr);
        end
        if (iq.en) begin
            isram_rdata = read_word(1'b1, iq.addr);
        end
    end

    always @(posedge clk) begin
        logic [31:0] r;
        r = $random(seed);
        #1;
        mac_ready = random_ready ? r[0] : 1'b1;
    end

    // compare every handshake against the reference
    always @(posedge clk) begin
        mac_batch_t exp_b;
        if (rst && mac_valid && mac_ready) begin
            if (received >= expected_batches) begin
                errors++;
                $display("FAILED at %0t: batch %0d beyond the expected count", $time, received);
            end else begin
                exp_b = expected_batch(received);
                check_equal("batch data", mac_batch.data, exp_b.data);
                check_equal("batch weight", mac_batch.weight, exp_b.weight);
                check_equal("batch header", {mac_batch.num_groups, mac_batch.macs_per_group,
                            mac_batch.out_row, mac_batch.out_col, mac_batch.oc_base},
                            {exp_b.num_groups, exp_b.macs_per_group, exp_b.out_row,
                            exp_b.out_col, exp_b.oc_base});
            end
            received++;
        end
    end

    task automatic run_layer();
        logic [31:0] st;
        received = 0;
        expected_batches = o_rows * o_cols * ((out_ch + groups - 1) / groups);
        apb_write(REG_CTRL, 32'h1);
        do begin
            apb_read(REG_STATUS, st);
        end while (!st[1]);
        check_equal("batch count", received, expected_batches);
        check_equal("status after layer", st[2:0], 3'b010);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] rnd;
        seed = 71;
        errors = 0;
        checks = 0;
        received = 0;
        expected_batches = 0;
        random_ready = 1'b0;
        rst = 1'b0;
        apb_req = '0;
        wsram_rdata = '0;
        isram_rdata = '0;
        mac_ready = 1'b0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            rnd = $random(seed);
            img_mem[i] = rnd[7:0];
            rnd = $random(seed);
            w_mem[i] = rnd[7:0];
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;

        // derived geometry readback
        set_layer(8, 8, 3, 3, 2, 5, 1, 1);
        apb_read(REG_INFO, rd);
        check_equal("info stride 1", rd, {8'(groups), 8'(mpg), 8'(o_cols), 8'(o_rows)});
        set_layer(8, 8, 3, 3, 2, 5, 2, 2);
        apb_read(REG_INFO, rd);
        check_equal("info stride 2", rd, {8'(groups), 8'(mpg), 8'(o_cols), 8'(o_rows)});
        // first offset past the register map
        apb_read(8'h1C, rd);

        set_layer(4, 5, 1, 1, 4, 20, 1, 1);
        run_layer();
        // rows of the window straddle SRAM words
        set_layer(7, 9, 3, 3, 3, 4, 2, 2);
        run_layer();
        // 7 channels in groups of 5 leave a short group
        set_layer(5, 6, 2, 2, 3, 7, 1, 2);
        run_layer();
        random_ready = 1'b1;
        set_layer(7, 9, 3, 3, 3, 4, 2, 2);
        run_layer();
        random_ready = 1'b0;

        // 81 MACs per group is refused
        set_layer(10, 10, 9, 9, 1, 1, 1, 1);
        received = 0;
        expected_batches = 0;
        apb_write(REG_CTRL, 32'h1);
        repeat (50) @(posedge clk);
        apb_read(REG_STATUS, rd);
        check_equal("status after illegal start", rd[2:0], 3'b100);
        check_equal("batches after illegal start", received, 0);

        errors += conv_feeder_top_i.conv_feeder_chk_i.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

// File: conv_feeder_chk.sv
`timescale 1ns/1ps

module conv_feeder_chk (
    input logic                 clk,
    input logic                 rst,
    input logic                 start_i,
    input logic                 done_i,
    input conv_pkg::sram_req_t  wsram_i,
    input conv_pkg::sram_req_t  isram_i,
    input logic                 mac_valid_i,
    input logic                 mac_ready_i,
    input conv_pkg::mac_batch_t mac_batch_i
);
    import conv_pkg::*;

    logic active;
    int   fail_count = 0;

    // layer in progress, from start pulse to done pulse
    always_ff @(posedge clk) begin
        if (!rst) begin
            active <= 1'b0;
        end else if (start_i) begin
            active <= 1'b1;
        end else if (done_i) begin
            active <= 1'b0;
        end
    end

    hold_batch: assert property (@(posedge clk) disable iff (!rst)
        mac_valid_i && !mac_ready_i |=> mac_valid_i && $stable(mac_batch_i))
        else begin
            $error("mac batch changed or dropped under back-pressure");
            fail_count = fail_count + 1;
        end

    idle_sram: assert property (@(posedge clk) disable iff (!rst)
        !active |-> !wsram_i.en && !isram_i.en)
        else begin
            $error("SRAM read while no layer is running");
            fail_count = fail_count + 1;
        end

    groups_nonzero: assert property (@(posedge clk) disable iff (!rst)
        mac_valid_i |-> mac_batch_i.num_groups != '0)
        else begin
            $error("valid batch with zero groups");
            fail_count = fail_count + 1;
        end

endmodule

bind conv_feeder_top conv_feeder_chk conv_feeder_chk_i (
    .clk         (clk),
    .rst         (rst),
    .start_i     (start),
    .done_i      (done),
    .wsram_i     (wsram_o),
    .isram_i     (isram_o),
    .mac_valid_i (mac_valid_o),
    .mac_ready_i (mac_ready_i),
    .mac_batch_i (mac_batch_o)
);

// File: conv_feeder_top.sv
`timescale 1ns/1ps

module conv_feeder_top (
    input  logic                 clk,
    input  logic                 rst,
    input  conv_pkg::apb_req_t   apb_req_i,
    output conv_pkg::apb_rsp_t   apb_rsp_o,
    output conv_pkg::sram_req_t  wsram_o,
    input  conv_pkg::sram_word_t wsram_rdata_i,
    output conv_pkg::sram_req_t  isram_o,
    input  conv_pkg::sram_word_t isram_rdata_i,
    output logic                 mac_valid_o,
    input  logic                 mac_ready_i,
    output conv_pkg::mac_batch_t mac_batch_o
);
    import conv_pkg::*;

    conv_cfg_t        cfg;
    logic             start;
    logic             done;
    logic             load;
    logic             loaded;
    logic             gather;
    logic             window_done;
    logic [DIM_W-1:0] oc_base;
    logic [DIM_W-1:0] out_row;
    logic [DIM_W-1:0] out_col;
    lanes_t           weight;
    lanes_t           window;

    conv_cfg_regs conv_cfg_regs_i (
        .clk       (clk),
        .rst       (rst),
        .apb_req_i (apb_req_i),
        .apb_rsp_o (apb_rsp_o),
        .done_i    (done),
        .cfg_o     (cfg),
        .start_o   (start)
    );

    conv_sequencer conv_sequencer_i (
        .clk           (clk),
        .rst           (rst),
        .cfg_i         (cfg),
        .start_i       (start),
        .done_o        (done),
        .load_o        (load),
        .loaded_i      (loaded),
        .oc_base_o     (oc_base),
        .weight_i      (weight),
        .gather_o      (gather),
        .out_row_o     (out_row),
        .out_col_o     (out_col),
        .window_done_i (window_done),
        .window_i      (window),
        .mac_valid_o   (mac_valid_o),
        .mac_ready_i   (mac_ready_i),
        .mac_batch_o   (mac_batch_o)
    );

    weight_loader weight_loader_i (
        .clk           (clk),
        .rst           (rst),
        .cfg_i         (cfg),
        .load_i        (load),
        .oc_base_i     (oc_base),
        .wsram_o       (wsram_o),
        .wsram_rdata_i (wsram_rdata_i),
        .loaded_o      (loaded),
        .weight_o      (weight)
    );

    window_gather window_gather_i (
        .clk           (clk),
        .rst           (rst),
        .cfg_i         (cfg),
        .gather_i      (gather),
        .out_row_i     (out_row),
        .out_col_i     (out_col),
        .isram_o       (isram_o),
        .isram_rdata_i (isram_rdata_i),
        .window_done_o (window_done),
        .window_o      (window)
    );

endmodule

// File: conv_sequencer.sv
`timescale 1ns/1ps

module conv_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  conv_pkg::conv_cfg_t        cfg_i,
    input  logic                       start_i,
    output logic                       done_o,
    output logic                       load_o,
    input  logic                       loaded_i,
    output logic [conv_pkg::DIM_W-1:0] oc_base_o,
    input  conv_pkg::lanes_t           weight_i,
    output logic                       gather_o,
    output logic [conv_pkg::DIM_W-1:0] out_row_o,
    output logic [conv_pkg::DIM_W-1:0] out_col_o,
    input  logic                       window_done_i,
    input  conv_pkg::lanes_t           window_i,
    output logic                       mac_valid_o,
    input  logic                       mac_ready_i,
    output conv_pkg::mac_batch_t       mac_batch_o
);
    import conv_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_LOAD, S_GATHER, S_EMIT} sstate_t;

    sstate_t          state;
    logic [DIM_W-1:0] num_groups;
    logic [15:0]      n_lanes;
    logic             handshake;
    logic             last_group;
    logic             last_col;
    logic             last_row;

    assign num_groups  = batch_groups(cfg_i, oc_base_o);
    assign n_lanes     = num_groups * cfg_i.macs_per_group;
    assign mac_valid_o = (state == S_EMIT);
    assign handshake   = mac_valid_o && mac_ready_i;
    // nine bits so oc_base + groups cannot wrap
    assign last_group  = ({1'b0, oc_base_o} + cfg_i.groups >= cfg_i.out_ch);
    assign last_col    = (out_col_o == cfg_i.out_cols - 1'b1);
    assign last_row    = (out_row_o == cfg_i.out_rows - 1'b1);
    assign done_o      = handshake && last_group && last_col && last_row;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= S_IDLE;
            load_o    <= 1'b0;
            gather_o  <= 1'b0;
            oc_base_o <= '0;
            out_row_o <= '0;
            out_col_o <= '0;
        end else begin
            load_o   <= 1'b0;
            gather_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        load_o    <= 1'b1;
                        oc_base_o <= '0;
                        out_row_o <= '0;
                        out_col_o <= '0;
                        state     <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    if (loaded_i) begin
                        gather_o <= 1'b1;
                        state    <= S_GATHER;
                    end
                end
                S_GATHER: begin
                    if (window_done_i) begin
                        state <= S_EMIT;
                    end
                end
                S_EMIT: begin
                    if (handshake && !last_group) begin
                        oc_base_o <= oc_base_o + cfg_i.groups;
                    end else if (handshake) begin
                        oc_base_o <= '0;
                        if (last_col && last_row) begin
                            state <= S_IDLE;
                        end else begin
                            // next position in row-major order
                            gather_o <= 1'b1;
                            state    <= S_GATHER;
                            if (last_col) begin
                                out_col_o <= '0;
                                out_row_o <= out_row_o + 1'b1;
                            end else begin
                                out_col_o <= out_col_o + 1'b1;
                            end
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // batch is built from held state, so it stays put under back-pressure
    always_comb begin
        logic [DIM_W-1:0] j;
        j = '0;
        mac_batch_o.data = '0;
        for (int l = 0; l < MAC_LANES; l++) begin
            if (l < n_lanes) begin
                mac_batch_o.data[l*DATA_W +: DATA_W] = window_i[j*DATA_W +: DATA_W];
            end
            // wrap to the start of the window at each group boundary
            j = (j == cfg_i.macs_per_group - 1'b1) ? '0 : j + 1'b1;
        end
        mac_batch_o.weight         = weight_i;
        mac_batch_o.num_groups     = num_groups;
        mac_batch_o.macs_per_group = cfg_i.macs_per_group;
        mac_batch_o.out_row        = out_row_o;
        mac_batch_o.out_col        = out_col_o;
        mac_batch_o.oc_base        = oc_base_o;
    end

endmodule

// File: window_gather.sv
`timescale 1ns/1ps

module window_gather (
    input  logic                       clk,
    input  logic                       rst,
    input  conv_pkg::conv_cfg_t        cfg_i,
    input  logic                       gather_i,
    input  logic [conv_pkg::DIM_W-1:0] out_row_i,
    input  logic [conv_pkg::DIM_W-1:0] out_col_i,
    output conv_pkg::sram_req_t        isram_o,
    input  conv_pkg::sram_word_t       isram_rdata_i,
    output logic                       window_done_o,
    output conv_pkg::lanes_t           window_o
);
    import conv_pkg::*;

    typedef enum logic [1:0] {G_IDLE, G_ROW, G_READ} gstate_t;

    gstate_t           state;
    logic [DATA_W-1:0] win [MAC_LANES];
    logic [DIM_W-1:0]  kr;
    logic [15:0]       span;
    logic [23:0]       row_start_c;
    logic [23:0]       row_start;
    logic [5:0]        base;
    logic [20:0]       wd;
    logic [20:0]       wd_last;
    logic [20:0]       rd_word_d;
    logic              issue;
    logic              last_row;
    logic              rd_pend;
    logic              rd_last_d;

    // bytes of one kernel row are contiguous in HWC order
    assign span = cfg_i.ker_cols * cfg_i.in_ch;
    assign row_start_c = ((out_row_i * cfg_i.stride_row + kr) * cfg_i.img_cols
                         + out_col_i * cfg_i.stride_col) * cfg_i.in_ch;

    assign issue        = (state == G_READ);
    assign last_row     = (kr == cfg_i.ker_rows - 1'b1);
    assign isram_o.en   = issue;
    assign isram_o.addr = wd[SRAM_AW-1:0];

    always_ff @(posedge clk) begin
        if (!rst) begin
            state         <= G_IDLE;
            kr            <= '0;
            rd_pend       <= 1'b0;
            rd_last_d     <= 1'b0;
            window_done_o <= 1'b0;
        end else begin
            rd_pend       <= issue;
            rd_last_d     <= issue && (wd == wd_last) && last_row;
            window_done_o <= rd_pend && rd_last_d;
            case (state)
                G_IDLE: begin
                    if (gather_i) begin
                        kr    <= '0;
                        state <= G_ROW;
                    end
                end
                G_ROW: state <= G_READ;
                G_READ: begin
                    if (wd == wd_last) begin
                        if (last_row) begin
                            state <= G_IDLE;
                        end else begin
                            kr    <= kr + 1'b1;
                            state <= G_ROW;
                        end
                    end
                end
                default: state <= G_IDLE;
            endcase
        end
    end

    // row setup, then one word per cycle
    always_ff @(posedge clk) begin
        rd_word_d <= wd;
        if (state == G_ROW) begin
            row_start <= row_start_c;
            base      <= 6'(kr * span);
            wd        <= 21'(row_start_c / SRAM_BYTES);
            wd_last   <= 21'((row_start_c + 24'(span) - 1'b1) / SRAM_BYTES);
        end else if (issue) begin
            wd <= wd + 1'b1;
        end
    end

    // keep only the bytes inside the row span
    always_ff @(posedge clk) begin
        logic [23:0] byte_addr;
        if (rd_pend) begin
            for (int b = 0; b < SRAM_BYTES; b++) begin
                byte_addr = 24'(rd_word_d * SRAM_BYTES + b);
                if (byte_addr >= row_start && byte_addr < row_start + span) begin
                    win[6'(base + byte_addr - row_start)] <=
                        isram_rdata_i[b*DATA_W +: DATA_W];
                end
            end
        end
    end

    always_comb begin
        for (int j = 0; j < MAC_LANES; j++) begin
            window_o[j*DATA_W +: DATA_W] = win[j];
        end
    end

endmodule

// File: weight_loader.sv
`timescale 1ns/1ps

module weight_loader (
    input  logic                       clk,
    input  logic                       rst,
    input  conv_pkg::conv_cfg_t        cfg_i,
    input  logic                       load_i,
    input  logic [conv_pkg::DIM_W-1:0] oc_base_i,
    output conv_pkg::sram_req_t        wsram_o,
    input  conv_pkg::sram_word_t       wsram_rdata_i,
    output logic                       loaded_o,
    output conv_pkg::lanes_t           weight_o
);
    import conv_pkg::*;

    logic [DATA_W-1:0] wbuf [WBUF_BYTES];
    logic        busy;
    logic        issue;
    logic        rd_pend;
    logic [6:0]  rd_idx;
    logic [5:0]  wr_idx;
    logic [6:0]  n_words;
    logic [15:0] total_bytes;
    logic [15:0] slice_base;
    logic [15:0] slice_lanes;

    assign total_bytes = cfg_i.out_ch * cfg_i.macs_per_group;
    // round up to whole words
    assign n_words = 7'((total_bytes + 16'(SRAM_BYTES - 1)) / SRAM_BYTES);

    assign issue        = busy && (rd_idx < n_words);
    assign wsram_o.en   = issue;
    assign wsram_o.addr = SRAM_AW'(rd_idx);

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy     <= 1'b0;
            rd_idx   <= '0;
            rd_pend  <= 1'b0;
            loaded_o <= 1'b0;
        end else begin
            loaded_o <= 1'b0;
            rd_pend  <= issue;
            if (load_i) begin
                busy   <= 1'b1;
                rd_idx <= '0;
            end else if (issue) begin
                rd_idx <= rd_idx + 1'b1;
            end else if (busy && rd_pend) begin
                // last word lands this cycle
                busy     <= 1'b0;
                loaded_o <= 1'b1;
            end
        end
    end

    // write index trails the read address by one cycle
    always_ff @(posedge clk) begin
        wr_idx <= rd_idx[5:0];
        if (rd_pend) begin
            for (int b = 0; b < SRAM_BYTES; b++) begin
                wbuf[9'(wr_idx * SRAM_BYTES + b)] <= wsram_rdata_i[b*DATA_W +: DATA_W];
            end
        end
    end

    assign slice_base  = oc_base_i * cfg_i.macs_per_group;
    assign slice_lanes = batch_groups(cfg_i, oc_base_i) * cfg_i.macs_per_group;

    always_comb begin
        for (int l = 0; l < MAC_LANES; l++) begin
            if (l < slice_lanes) begin
                weight_o[l*DATA_W +: DATA_W] = wbuf[9'(slice_base + l)];
            end else begin
                weight_o[l*DATA_W +: DATA_W] = '0;
            end
        end
    end

endmodule

// File: conv_cfg_regs.sv
`timescale 1ns/1ps

module conv_cfg_regs (
    input  logic                clk,
    input  logic                rst,
    input  conv_pkg::apb_req_t  apb_req_i,
    output conv_pkg::apb_rsp_t  apb_rsp_o,
    input  logic                done_i,
    output conv_pkg::conv_cfg_t cfg_o,
    output logic                start_o
);
    import conv_pkg::*;

    logic [DIM_W-1:0] img_rows;
    logic [DIM_W-1:0] img_cols;
    logic [DIM_W-1:0] ker_rows;
    logic [DIM_W-1:0] ker_cols;
    logic [DIM_W-1:0] in_ch;
    logic [DIM_W-1:0] out_ch;
    logic [3:0]       stride_row;
    logic [3:0]       stride_col;
    logic             busy;
    logic             done;
    logic             err;
    logic [23:0]      macs_full;
    logic [31:0]      wbytes_full;
    logic             mpg_ok;
    logic [6:0]       mpg_div;
    logic [DIM_W-1:0] groups_fit;
    logic             legal;
    logic             access;
    logic             wr_en;
    logic             mapped;

    assign access = apb_req_i.psel && apb_req_i.penable;
    assign wr_en  = access && apb_req_i.pwrite;

    assign macs_full   = ker_rows * ker_cols * in_ch;
    assign wbytes_full = out_ch * macs_full;
    assign mpg_ok      = (macs_full != '0) && (macs_full <= MAC_LANES);
    // divisor kept nonzero for illegal shapes
    assign mpg_div     = mpg_ok ? macs_full[6:0] : 7'd64;
    assign groups_fit  = DIM_W'(MAC_LANES / mpg_div);

    assign legal = mpg_ok && (wbytes_full <= WBUF_BYTES) && (out_ch != '0)
                && (stride_row != '0) && (stride_col != '0)
                && (img_rows != '0) && (img_cols != '0)
                && (ker_rows <= img_rows) && (ker_cols <= img_cols);

    always_comb begin
        cfg_o.img_rows   = img_rows;
        cfg_o.img_cols   = img_cols;
        cfg_o.ker_rows   = ker_rows;
        cfg_o.ker_cols   = ker_cols;
        cfg_o.in_ch      = in_ch;
        cfg_o.out_ch     = out_ch;
        cfg_o.stride_row = stride_row;
        cfg_o.stride_col = stride_col;
        // valid convolution, no padding
        cfg_o.out_rows = (stride_row == '0 || ker_rows > img_rows) ? '0
                       : DIM_W'((img_rows - ker_rows) / stride_row + 1);
        cfg_o.out_cols = (stride_col == '0 || ker_cols > img_cols) ? '0
                       : DIM_W'((img_cols - ker_cols) / stride_col + 1);
        cfg_o.macs_per_group = (macs_full > 24'd255) ? 8'hff : macs_full[7:0];
        cfg_o.groups = !mpg_ok ? '0 : ((groups_fit < out_ch) ? groups_fit : out_ch);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            img_rows   <= '0;
            img_cols   <= '0;
            ker_rows   <= '0;
            ker_cols   <= '0;
            in_ch      <= '0;
            out_ch     <= '0;
            stride_row <= '0;
            stride_col <= '0;
            busy       <= 1'b0;
            done       <= 1'b0;
            err        <= 1'b0;
            start_o    <= 1'b0;
        end else begin
            start_o <= 1'b0;
            if (done_i) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (wr_en) begin
                case (apb_req_i.paddr)
                    REG_CTRL: begin
                        if (apb_req_i.pwdata[0] && !busy) begin
                            done <= 1'b0;
                            err  <= !legal;
                            if (legal) begin
                                start_o <= 1'b1;
                                busy    <= 1'b1;
                            end
                        end
                    end
                    REG_IMG: begin
                        img_rows <= apb_req_i.pwdata[7:0];
                        img_cols <= apb_req_i.pwdata[15:8];
                    end
                    REG_KER: begin
                        ker_rows <= apb_req_i.pwdata[7:0];
                        ker_cols <= apb_req_i.pwdata[15:8];
                        in_ch    <= apb_req_i.pwdata[23:16];
                    end
                    REG_OCH: out_ch <= apb_req_i.pwdata[7:0];
                    REG_STRIDE: begin
                        stride_row <= apb_req_i.pwdata[3:0];
                        stride_col <= apb_req_i.pwdata[7:4];
                    end
                    default: ;
                endcase
            end
        end
    end

    // zero wait state read path
    always_comb begin
        apb_rsp_o.pready = 1'b1;
        apb_rsp_o.prdata = '0;
        mapped = 1'b1;
        case (apb_req_i.paddr)
            REG_CTRL:   apb_rsp_o.prdata = '0;
            REG_STATUS: apb_rsp_o.prdata = {29'b0, err, done, busy};
            REG_IMG:    apb_rsp_o.prdata = {16'b0, img_cols, img_rows};
            REG_KER:    apb_rsp_o.prdata = {8'b0, in_ch, ker_cols, ker_rows};
            REG_OCH:    apb_rsp_o.prdata = {24'b0, out_ch};
            REG_STRIDE: apb_rsp_o.prdata = {24'b0, stride_col, stride_row};
            REG_INFO:   apb_rsp_o.prdata = {cfg_o.groups, cfg_o.macs_per_group,
                                            cfg_o.out_cols, cfg_o.out_rows};
            default:    mapped = 1'b0;
        endcase
        apb_rsp_o.pslverr = access && !mapped;
    end

endmodule

// File: conv_pkg.sv
package conv_pkg;

    // datapath sizes
    localparam int MAC_LANES  = 64;
    localparam int DATA_W     = 8;
    localparam int SRAM_BYTES = 8;
    localparam int SRAM_AW    = 16;
    localparam int WBUF_BYTES = 512;
    localparam int DIM_W      = 8;

    // apb register map
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_IMG    = 8'h08;
    localparam logic [7:0] REG_KER    = 8'h0C;
    localparam logic [7:0] REG_OCH    = 8'h10;
    localparam logic [7:0] REG_STRIDE = 8'h14;
    localparam logic [7:0] REG_INFO   = 8'h18;

    typedef logic [MAC_LANES*DATA_W-1:0]  lanes_t;
    typedef logic [SRAM_BYTES*DATA_W-1:0] sram_word_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [DIM_W-1:0] img_rows;
        logic [DIM_W-1:0] img_cols;
        logic [DIM_W-1:0] ker_rows;
        logic [DIM_W-1:0] ker_cols;
        logic [DIM_W-1:0] in_ch;
        logic [DIM_W-1:0] out_ch;
        logic [3:0]       stride_row;
        logic [3:0]       stride_col;
        logic [DIM_W-1:0] out_rows;
        logic [DIM_W-1:0] out_cols;
        logic [DIM_W-1:0] macs_per_group;
        logic [DIM_W-1:0] groups;
    } conv_cfg_t;

    typedef struct packed {
        logic               en;
        logic [SRAM_AW-1:0] addr;
    } sram_req_t;

    typedef struct packed {
        lanes_t           data;
        lanes_t           weight;
        logic [DIM_W-1:0] num_groups;
        logic [DIM_W-1:0] macs_per_group;
        logic [DIM_W-1:0] out_row;
        logic [DIM_W-1:0] out_col;
        logic [DIM_W-1:0] oc_base;
    } mac_batch_t;

    // groups in the batch starting at oc_base, the last one may be short
    function automatic logic [DIM_W-1:0] batch_groups(conv_cfg_t cfg,
                                                      logic [DIM_W-1:0] oc_base);
        logic [DIM_W-1:0] left;
        left = cfg.out_ch - oc_base;
        return (cfg.groups < left) ? cfg.groups : left;
    endfunction

endpackage
